/* logic/soc_defines.svh */
////////////////////////////////////////
// Sizes and fixed values of the SoC bus fabric.
// Include wherever a memory size or constant word is needed.
////////////////////////////////////////
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// RAM depth in 32-bit words.
`define SOC_RAM_WORDS 256

// Transmit FIFO entries, a power of two.
`define SOC_UART_FIFO_DEPTH 8

`define SOC_UART_DIV_RESET 32'd16 // Clocks per bit after reset.

`define SOC_VERSION 32'h0001_8000

// Returned by reads from holes in the map.
`define SOC_UNMAPPED_RDATA 32'hdeadbeef

`endif

/* logic/soc_pkg.sv */
////////////////////////////////////////
// Bus types shared by the fabric and its targets.
////////////////////////////////////////
`default_nettype none

package soc_pkg;

	////////////////////////////////////////
	// Memory bus
	////////////////////////////////////////

	// Held by the master until ready.
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb; // Zero for a read.
	} bus_req_t;

	typedef struct packed {
		logic        ready; // One cycle per transfer.
		logic [31:0] rdata;
	} bus_rsp_t;

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////

	// Top nibble of the address. Other values are unmapped.
	typedef enum logic [3:0] {
		region_ram  = 4'h0,
		region_uart = 4'h1,
		region_ctrl = 4'h2
	} region_e;

endpackage

`default_nettype wire

/* logic/bus_decoder.sv */
////////////////////////////////////////
// Routes master requests to one target by the top address nibble.
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps
`include "soc_defines.svh"

module bus_decoder import soc_pkg::*; (
	input  logic     clk48m,
	input  logic     resetn,
	input  bus_req_t req,
	output bus_rsp_t rsp,
	output bus_req_t ram_req,
	output bus_req_t uart_req,
	output bus_req_t ctrl_req,
	input  bus_rsp_t ram_rsp,
	input  bus_rsp_t uart_rsp,
	input  bus_rsp_t ctrl_rsp
);

	logic sel_ram;
	logic sel_uart;
	logic sel_ctrl;

	always_comb begin
		sel_ram = 1'b0;
		sel_uart = 1'b0;
		sel_ctrl = 1'b0;
		case (req.addr[31:28])
			region_ram:  sel_ram = 1'b1;
			region_uart: sel_uart = 1'b1;
			region_ctrl: sel_ctrl = 1'b1;
			default: ; // Hole in the map.
		endcase
	end

	// Only the selected target sees valid.
	always_comb begin
		ram_req = req;
		uart_req = req;
		ctrl_req = req;
		ram_req.valid = req.valid && sel_ram;
		uart_req.valid = req.valid && sel_uart;
		ctrl_req.valid = req.valid && sel_ctrl;
	end

	always_comb begin
		if (sel_ram) begin
			rsp = ram_rsp;
		end else if (sel_uart) begin
			rsp = uart_rsp;
		end else if (sel_ctrl) begin
			rsp = ctrl_rsp;
		end else begin
			rsp.ready = req.valid; // Unmapped answers at once.
			rsp.rdata = `SOC_UNMAPPED_RDATA;
		end
	end

	a_one_ready: assert property (@(posedge clk48m) disable iff (!resetn)
		$onehot0({ram_rsp.ready, uart_rsp.ready, ctrl_rsp.ready}));

	// Master must hold its request until accepted.
	a_addr_hold: assert property (@(posedge clk48m) disable iff (!resetn)
		req.valid && !rsp.ready |=> req.valid && $stable(req.addr));

endmodule

`default_nettype wire

/* logic/word_ram.sv */
////////////////////////////////////////
// Word RAM target with byte strobes, ready one cycle after the request.
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps
`include "soc_defines.svh"

module word_ram import soc_pkg::*; (
	input  logic     clk48m,
	input  logic     resetn,
	input  bus_req_t req,
	output bus_rsp_t rsp
);

	localparam int WORDS = `SOC_RAM_WORDS;
	localparam int AW = $clog2(WORDS);

	logic [31:0]   mem [WORDS];
	logic [AW-1:0] idx;
	logic          access;
	logic          ready_q;
	logic [31:0]   rdata_q;

	assign idx = req.addr[AW+1:2];
	assign access = req.valid && !ready_q; // Skip the acknowledge cycle.

	always_ff @(posedge clk48m) begin
		if (access) begin
			for (int b = 0; b < 4; b++) begin
				if (req.wstrb[b]) begin
					mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
				end
			end
			rdata_q <= mem[idx];
		end
	end

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	assign rsp.ready = ready_q;
	assign rsp.rdata = rdata_q;

	// The acknowledged request is the one served a cycle earlier.
	a_ready_same_req: assert property (@(posedge clk48m) disable iff (!resetn)
		rsp.ready |-> req.valid && $stable(req));

endmodule

`default_nettype wire

/* logic/ctrl_regs.sv */
////////////////////////////////////////
// LED and general output registers with readback and version word.
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps
`include "soc_defines.svh"

module ctrl_regs import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        resetn,
	input  bus_req_t    req,
	output bus_rsp_t    rsp,
	output logic [5:0]  led,
	output logic [23:0] genio
);

	logic [2:0] index;
	logic       wr_en;

	assign index = req.addr[4:2];
	assign wr_en = req.valid && req.wstrb[0];

	////////////////////////////////////////
	// Register writes
	////////////////////////////////////////

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			led <= '0;
			genio <= '0;
		end else if (wr_en) begin
			if (index == 3'd0) begin
				led <= req.wdata[5:0];
			end else if (index == 3'd1) begin
				genio <= req.wdata[23:0];
			end
		end
	end

	////////////////////////////////////////
	// Readback
	////////////////////////////////////////

	always_comb begin
		case (index)
			3'd0:    rsp.rdata = {26'd0, led};
			3'd1:    rsp.rdata = {8'd0, genio};
			3'd2:    rsp.rdata = `SOC_VERSION;
			default: rsp.rdata = '0;
		endcase
	end

	assign rsp.ready = req.valid; // Same-cycle acknowledge.

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
////////////////////////////////////////
// Transmit UART with byte FIFO. Data register at offset 0, divider at 4.
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps
`include "soc_defines.svh"

module uart_tx import soc_pkg::*; (
	input  logic     clk48m,
	input  logic     resetn,
	input  bus_req_t req,
	output bus_rsp_t rsp,
	output logic     ser_tx
);

	localparam int DEPTH = `SOC_UART_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = PTR_W + 1;

	logic [31:0]      div_q;
	logic [7:0]       fifo_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fifo_cnt;
	logic [CNT_W-1:0] free_cnt;
	logic             fifo_full;
	logic             fifo_empty;
	logic             dat_sel;
	logic             dat_wr;
	logic             push;
	logic             pop;
	logic [9:0]       tx_shift;
	logic [3:0]       tx_bits;
	logic [31:0]      tx_clk;
	logic [31:0]      tx_div;
	logic             bit_end;

	assign dat_sel = !req.addr[2];
	assign dat_wr = req.valid && dat_sel && req.wstrb[0];
	assign fifo_full = fifo_cnt == CNT_W'(DEPTH);
	assign fifo_empty = fifo_cnt == '0;
	assign free_cnt = CNT_W'(DEPTH) - fifo_cnt;
	assign push = dat_wr && !fifo_full;

	assign rsp.ready = req.valid && !(dat_wr && fifo_full); // Stall on full.
	assign rsp.rdata = dat_sel ? {{(32-CNT_W){1'b0}}, free_cnt} : div_q;

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			div_q <= `SOC_UART_DIV_RESET;
		end else if (req.valid && !dat_sel && req.wstrb[0]) begin
			div_q <= req.wdata;
		end
	end

	////////////////////////////////////////
	// Transmit FIFO
	////////////////////////////////////////

	always_ff @(posedge clk48m) begin
		if (push) begin
			fifo_mem[wr_ptr] <= req.wdata[7:0];
		end
	end

	// Pointers wrap on their own.
	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
				2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Serializer
	////////////////////////////////////////

	assign bit_end = tx_clk == tx_div - 32'd1;
	// Load on idle or at the end of the stop bit.
	assign pop = !fifo_empty && (tx_bits == '0 || (tx_bits == 4'd1 && bit_end));

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			tx_shift <= '1;
			tx_bits <= '0;
			tx_clk <= '0;
			tx_div <= `SOC_UART_DIV_RESET;
		end else if (pop) begin
			tx_shift <= {1'b1, fifo_mem[rd_ptr], 1'b0}; // Stop, data, start.
			tx_bits <= 4'd10;
			tx_clk <= '0;
			tx_div <= div_q; // Divider fixed per frame.
		end else if (tx_bits != '0) begin
			if (bit_end) begin
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx_bits <= tx_bits - 4'd1;
				tx_clk <= '0;
			end else begin
				tx_clk <= tx_clk + 32'd1;
			end
		end
	end

	assign ser_tx = tx_shift[0];

	// Write pointer holds while full.
	a_no_push_full: assert property (@(posedge clk48m) disable iff (!resetn)
		fifo_full |=> $stable(wr_ptr));

	// Read pointer holds while empty.
	a_no_pop_empty: assert property (@(posedge clk48m) disable iff (!resetn)
		fifo_empty |=> $stable(rd_ptr));

endmodule

`default_nettype wire

/* logic/soc_fabric.sv */
////////////////////////////////////////
// Bus fabric top. The CPU side connects to req and rsp.
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module soc_fabric import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        resetn,
	input  bus_req_t    req,
	output bus_rsp_t    rsp,
	output logic [5:0]  led,
	output logic [23:0] genio,
	output logic        ser_tx
);

	bus_req_t ram_req;
	bus_req_t uart_req;
	bus_req_t ctrl_req;
	bus_rsp_t ram_rsp;
	bus_rsp_t uart_rsp;
	bus_rsp_t ctrl_rsp;

	bus_decoder decoder0 (
		.clk48m   (clk48m),
		.resetn   (resetn),
		.req      (req),
		.rsp      (rsp),
		.ram_req  (ram_req),
		.uart_req (uart_req),
		.ctrl_req (ctrl_req),
		.ram_rsp  (ram_rsp),
		.uart_rsp (uart_rsp),
		.ctrl_rsp (ctrl_rsp)
	);

	word_ram ram0 (
		.clk48m (clk48m),
		.resetn (resetn),
		.req    (ram_req),
		.rsp    (ram_rsp)
	);

	ctrl_regs ctrl0 (
		.clk48m (clk48m),
		.resetn (resetn),
		.req    (ctrl_req),
		.rsp    (ctrl_rsp),
		.led    (led),
		.genio  (genio)
	);

	uart_tx uart0 (
		.clk48m (clk48m),
		.resetn (resetn),
		.req    (uart_req),
		.rsp    (uart_rsp),
		.ser_tx (ser_tx)
	);

endmodule

`default_nettype wire

/* verif/soc_model.svh */
////////////////////////////////////////
// Reference model of the fabric targets.
// Included inside the testbench module.
////////////////////////////////////////
`ifndef SOC_MODEL_SVH
`define SOC_MODEL_SVH

logic [31:0] ram_image [`SOC_RAM_WORDS];
logic [5:0]  exp_led;
logic [23:0] exp_genio;
logic [31:0] exp_div;
logic [7:0]  tx_expected [$]; // Bytes in write order.

function automatic void init_reference();
	exp_led = '0;
	exp_genio = '0;
	exp_div = `SOC_UART_DIV_RESET;
	tx_expected.delete();
endfunction

// Low word-address bits pick the RAM word.
function automatic void ram_merge(input logic [31:0] addr, input logic [31:0] wdata,
	input logic [3:0] wstrb);
	int idx;
	idx = int'((addr >> 2) % `SOC_RAM_WORDS);
	for (int b = 0; b < 4; b++) begin
		if (wstrb[b]) ram_image[idx][8*b +: 8] = wdata[8*b +: 8];
	end
endfunction

function automatic logic [31:0] ram_lookup(input logic [31:0] addr);
	return ram_image[int'((addr >> 2) % `SOC_RAM_WORDS)];
endfunction

function automatic void ctrl_store(input logic [31:0] addr, input logic [31:0] wdata);
	if (addr[4:2] == 3'd0) exp_led = wdata[5:0];
	else if (addr[4:2] == 3'd1) exp_genio = wdata[23:0];
endfunction

function automatic logic [31:0] ctrl_lookup(input logic [31:0] addr);
	case (addr[4:2])
		3'd0:    return {26'd0, exp_led};
		3'd1:    return {8'd0, exp_genio};
		3'd2:    return `SOC_VERSION;
		default: return '0;
	endcase
endfunction

function automatic bit mapped_region(input logic [31:0] addr);
	case (addr[31:28])
		region_ram, region_uart, region_ctrl: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

`endif

/* verif/soc_tb.sv */
////////////////////////////////////////
// Testbench for the bus fabric. Plays the CPU
// and decodes the UART line.
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_tb import soc_pkg::*; ();

	localparam int TIMEOUT = 20000; // Cycles per wait.
	localparam int DEPTH = `SOC_UART_FIFO_DEPTH;

	logic        clk48m;
	logic        resetn;
	bus_req_t    req;
	bus_rsp_t    rsp;
	logic [5:0]  led;
	logic [23:0] genio;
	logic        ser_tx;
	logic [7:0]  rx_bytes [$];

	`include "soc_model.svh"

	soc_fabric dut0 (
		.clk48m (clk48m),
		.resetn (resetn),
		.req    (req),
		.rsp    (rsp),
		.led    (led),
		.genio  (genio),
		.ser_tx (ser_tx)
	);

	initial begin
		clk48m = 1'b0;
		forever #2 clk48m = ~clk48m;
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	// Starts on the edge that completed the previous transfer.
	task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata, output int waits);
		int n;
		n = 0;
		@(posedge clk48m);
		req <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
		@(negedge clk48m);
		while (!rsp.ready) begin
			n++;
			if (n > TIMEOUT) report_failure($sformatf("No ready for address %h", addr));
			@(negedge clk48m);
		end
		rdata = rsp.rdata;
		waits = n;
	endtask

	task automatic bus_idle();
		@(posedge clk48m);
		req <= '0;
	endtask

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
	endfunction

	////////////////////////////////////////
	// UART line decoder
	////////////////////////////////////////

	initial begin : uart_monitor
		int         idle;
		int         div;
		logic [7:0] rx_byte;
		forever begin
			idle = 0;
			@(negedge clk48m);
			while (ser_tx !== 1'b0) begin
				if (tx_expected.size() > rx_bytes.size()) idle++;
				if (idle > TIMEOUT) report_failure("UART line stayed idle with bytes pending");
				@(negedge clk48m);
			end
			div = int'(exp_div);
			repeat (div / 2) @(negedge clk48m); // Middle of the start bit.
			if (ser_tx !== 1'b0) report_failure("UART start bit ended early");
			for (int i = 0; i < 8; i++) begin
				repeat (div) @(negedge clk48m);
				rx_byte[i] = ser_tx;
			end
			repeat (div) @(negedge clk48m);
			if (ser_tx !== 1'b1) report_failure("UART stop bit was not high");
			rx_bytes.push_back(rx_byte);
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [3:0]  wstrb;
		int          waits;
		int          stalls;
		int          n;
		void'($urandom(32'h37a1));
		req = '0;
		resetn = 1'b0;
		init_reference();
		repeat (2) @(posedge clk48m);
		resetn <= 1'b1;

		@(negedge clk48m);
		check_value("LED after reset", 32'(led), 32'(exp_led));
		check_value("GPIO after reset", 32'(genio), 32'(exp_genio));
		check_value("Serial line after reset", 32'(ser_tx), 32'd1);
		check_value("Idle ready", 32'(rsp.ready), 32'd0);
		bus_xfer(32'h1000_0004, '0, 4'h0, rdata, waits);
		check_value("Divider after reset", rdata, exp_div);

		// Every RAM word gets a known value first.
		for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
			addr = 32'(i) << 2;
			bus_xfer(addr, fill_word(addr), 4'hf, rdata, waits);
			ram_merge(addr, fill_word(addr), 4'hf);
		end
		for (int i = 0; i < 400; i++) begin
			addr = $urandom() & 32'h0fff_fffc;
			wdata = $urandom();
			wstrb = ($urandom() % 2 == 0) ? 4'(($urandom() % 16)) : 4'h0;
			bus_xfer(addr, wdata, wstrb, rdata, waits);
			if (wstrb == 4'h0) check_value("RAM read", rdata, ram_lookup(addr));
			else ram_merge(addr, wdata, wstrb);
		end

		for (int i = 0; i < 60; i++) begin
			addr = 32'h2000_0000 | (($urandom() % 8) << 2);
			wdata = $urandom();
			if (addr[4:3] == 2'b00 && $urandom() % 2 == 0) begin
				bus_xfer(addr, wdata, 4'hf, rdata, waits);
				ctrl_store(addr, wdata);
				bus_idle();
				@(negedge clk48m);
				check_value("LED output", 32'(led), 32'(exp_led));
				check_value("GPIO output", 32'(genio), 32'(exp_genio));
			end else begin
				bus_xfer(addr, '0, 4'h0, rdata, waits);
				check_value("Control register read", rdata, ctrl_lookup(addr));
			end
		end

		for (int r = 0; r < 16; r++) begin
			wdata = $urandom();
			addr = {4'(r), wdata[27:0]};
			if (!mapped_region(addr)) begin
				bus_xfer(addr, '0, 4'h0, rdata, waits);
				check_value("Unmapped read", rdata, `SOC_UNMAPPED_RDATA);
			end
		end

		////////////////////////////////////////
		// UART
		////////////////////////////////////////

		wdata = 32'd4 + ($urandom() % 13);
		bus_xfer(32'h1000_0004, wdata, 4'hf, rdata, waits);
		exp_div = wdata;
		bus_xfer(32'h1000_0004, '0, 4'h0, rdata, waits);
		check_value("Divider readback", rdata, exp_div);
		bus_xfer(32'h1000_0000, '0, 4'h0, rdata, waits);
		check_value("Free FIFO entries", rdata, 32'(DEPTH));

		stalls = 0;
		for (int i = 0; i < DEPTH + 6; i++) begin
			wdata = $urandom() & 32'hff;
			bus_xfer(32'h1000_0000, wdata, 4'h1, rdata, waits);
			tx_expected.push_back(wdata[7:0]);
			if (waits > 0) stalls++;
		end
		bus_idle();
		check_value("Writes held on a full FIFO", 32'(stalls > 0), 32'd1);

		n = 0;
		while (rx_bytes.size() < tx_expected.size()) begin
			n++;
			if (n > TIMEOUT) report_failure("UART did not send every written byte");
			@(negedge clk48m);
		end
		for (int i = 0; i < tx_expected.size(); i++) begin
			check_value($sformatf("UART byte %0d", i), 32'(rx_bytes[i]),
				32'(tx_expected[i]));
		end
		bus_xfer(32'h1000_0000, '0, 4'h0, rdata, waits);
		check_value("Free FIFO entries when drained", rdata, 32'(DEPTH));
		bus_idle();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
+incdir+verif
logic/soc_pkg.sv
logic/bus_decoder.sv
logic/word_ram.sv
logic/ctrl_regs.sv
logic/uart_tx.sv
logic/soc_fabric.sv
verif/soc_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module soc_tb -o soc_sim &&
./obj_dir/soc_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "Simulation passed." ||
{ echo "Simulation failed."; exit 1; }
